// ==== verilog/spi_pkg.sv ====
// Mode 3 only with a fixed 8-bit word. SCLK_HALF_CYCLES must be even and at least 2
package spi_pkg;

   // ---------------------------------------------------------------------
   // Word and serial clock sizing
   // ---------------------------------------------------------------------
   localparam int SPI_WORD_BITS    = 8;                         // Bits per transfer
   localparam int SCLK_HALF_CYCLES = 4;                         // clk cycles per sclk half
   localparam int SCLK_CNT_BITS    = $clog2(SCLK_HALF_CYCLES);  // Divider counter width
   localparam int BIT_CNT_BITS     = $clog2(SPI_WORD_BITS + 1); // Holds 0..SPI_WORD_BITS

   // Byte payload for tx, rx and user data
   typedef logic [SPI_WORD_BITS-1:0] spi_word_t;

   // ---------------------------------------------------------------------
   // Transfer controller states
   // ---------------------------------------------------------------------
   typedef enum logic [1:0] {
      XFER_IDLE   = 2'd0,  // Waiting for start
      XFER_SHIFT  = 2'd1,  // sclk running, bits moving
      XFER_FINISH = 2'd2   // One cycle to latch rx and signal done
   } xfer_state_t;

endpackage

// ==== verilog/spi_phase_if.sv ====
// Strobes are one clk cycle wide and only toggle while run is high
`timescale 1ns/1ps

interface spi_phase_if;

   logic run;   // Controller enables the divider
   logic sclk;  // Serial clock level, idles high
   logic rise;  // One cycle after sclk goes high
   logic fall;  // One cycle after sclk goes low

   // Divider owns the clock and its edge strobes
   modport gen (
      input  run,
      output sclk,
      output rise,
      output fall
   );

   // Controller starts and stops the clock, counts rises
   modport ctrl (
      output run,
      input  rise
   );

   // Shift datapath only reacts to the strobes
   modport shift (
      input rise,
      input fall
   );

endinterface

// ==== verilog/spi_sclk_gen.sv ====
// sclk is forced high while run is low, so a stopped clock never leaves a stray edge
`timescale 1ns/1ps

module spi_sclk_gen (
   input  logic     clk,
   input  logic     rst,
   spi_phase_if.gen phase
);

   import spi_pkg::*;

   logic [SCLK_CNT_BITS-1:0] div_cnt;  // Counts clk cycles within a half period
   logic                     sclk_q;   // Generated serial clock
   logic                     sclk_d;   // Delayed copy for edge detection
   logic                     half_end; // Last cycle of a half period

   assign half_end = (div_cnt == SCLK_CNT_BITS'(SCLK_HALF_CYCLES - 1));

   // ---------------------------------------------------------------------
   // Divider and serial clock register
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         div_cnt <= '0;
         sclk_q  <= 1'b1;                 // CPOL = 1
      end else if (!phase.run) begin
         div_cnt <= '0;                   // Restart phase on next transfer
         sclk_q  <= 1'b1;                 // Park high between transfers
      end else if (half_end) begin
         div_cnt <= '0;
         sclk_q  <= ~sclk_q;              // Half period done
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Delayed copy, reset to the idle level so no strobe fires out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sclk_d <= 1'b1;
      end else begin
         sclk_d <= sclk_q;
      end
   end

   // ---------------------------------------------------------------------
   // Edge strobes
   // ---------------------------------------------------------------------
   // High in the cycle after the toggle, while sclk_d still holds the old level
   assign phase.rise = sclk_q & ~sclk_d;  // Low to high, sample point
   assign phase.fall = ~sclk_q & sclk_d;  // High to low, drive point

   assign phase.sclk = sclk_q;

endmodule

// ==== verilog/spi_shift_unit.sv ====
// Strobes are ignored unless shift_en is high; rx_data only changes on capture
`timescale 1ns/1ps

module spi_shift_unit (
   input  logic               clk,
   input  logic               rst,
   input  logic               load,      // Start of transfer
   input  logic               capture,   // End of transfer
   input  logic               shift_en,  // Shift state active
   input  spi_pkg::spi_word_t tx_data,
   input  logic               miso,
   output logic               mosi,
   output spi_pkg::spi_word_t rx_data,
   spi_phase_if.shift         phase
);

   import spi_pkg::*;

   spi_word_t tx_reg;     // Bits still to present, MSB next
   spi_word_t rx_reg;     // Assembles miso samples
   logic      drive_bit;  // Fall strobe inside a transfer
   logic      sample_bit; // Rise strobe inside a transfer

   assign drive_bit  = shift_en & phase.fall;
   assign sample_bit = shift_en & phase.rise;

   // ---------------------------------------------------------------------
   // Transmit side
   // ---------------------------------------------------------------------
   // The leading fall of mode 3 re-drives bit 7 from tx_reg, so mosi holds
   // steady there and each later fall moves one bit down
   always_ff @(posedge clk) begin
      if (load) begin
         tx_reg <= tx_data;
      end else if (drive_bit) begin
         tx_reg <= {tx_reg[SPI_WORD_BITS-2:0], 1'b0};  // MSB first
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mosi <= 1'b0;
      end else if (load) begin
         mosi <= tx_data[SPI_WORD_BITS-1];  // Bit 7 valid with cs_n
      end else if (drive_bit) begin
         mosi <= tx_reg[SPI_WORD_BITS-1];
      end
   end

   // ---------------------------------------------------------------------
   // Receive side
   // ---------------------------------------------------------------------
   // Eight rises replace every bit, so no clear at load
   always_ff @(posedge clk) begin
      if (sample_bit) begin
         rx_reg <= {rx_reg[SPI_WORD_BITS-2:0], miso};
      end
   end

   // User copy, stable from one done to the next
   always_ff @(posedge clk) begin
      if (rst) begin
         rx_data <= '0;
      end else if (capture) begin
         rx_data <= rx_reg;
      end
   end

endmodule

// ==== verilog/spi_transfer_ctrl.sv ====
// start is only sampled in idle; busy, cs_n and done are registered outputs
`timescale 1ns/1ps

module spi_transfer_ctrl (
   input  logic      clk,
   input  logic      rst,
   input  logic      start,     // User pulse
   output logic      cs_n,      // Active-low chip select
   output logic      busy,      // High from accept to done
   output logic      done,      // One cycle, rx_data valid
   output logic      load,      // To shift unit
   output logic      capture,   // To shift unit
   output logic      shift_en,  // To shift unit
   spi_phase_if.ctrl phase
);

   import spi_pkg::*;

   xfer_state_t             state;
   xfer_state_t             state_nxt;
   logic [BIT_CNT_BITS-1:0] bit_cnt;    // Rises still expected
   logic                    accept;     // Start taken this cycle
   logic                    last_rise;  // Final sample of the word

   assign accept    = (state == XFER_IDLE) && start;
   assign last_rise = phase.rise && (bit_cnt == BIT_CNT_BITS'(1));

   // ---------------------------------------------------------------------
   // Next state
   // ---------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         XFER_IDLE: begin
            if (start) begin
               state_nxt = XFER_SHIFT;
            end
         end
         XFER_SHIFT: begin
            // sclk is back high here, so stopping leaves no extra edge
            if (last_rise) begin
               state_nxt = XFER_FINISH;
            end
         end
         XFER_FINISH: begin
            state_nxt = XFER_IDLE;          // Always a single cycle
         end
         default: begin
            state_nxt = XFER_IDLE;
         end
      endcase
   end

   // ---------------------------------------------------------------------
   // State, bit counter and user status
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= XFER_IDLE;
         bit_cnt <= '0;
         cs_n    <= 1'b1;
         busy    <= 1'b0;
         done    <= 1'b0;
      end else begin
         state <= state_nxt;
         cs_n  <= (state_nxt == XFER_IDLE);   // Low from accept through finish
         busy  <= (state_nxt != XFER_IDLE);
         done  <= (state == XFER_FINISH);     // Lands with the new rx_data

         if (accept) begin
            bit_cnt <= BIT_CNT_BITS'(SPI_WORD_BITS);
         end else if ((state == XFER_SHIFT) && phase.rise) begin
            bit_cnt <= bit_cnt - 1'b1;        // One per sampled bit
         end
      end
   end

   // ---------------------------------------------------------------------
   // Datapath controls
   // ---------------------------------------------------------------------
   // Mode 3 leads with a fall that only re-drives bit 7, and the first
   // counted strobe is a rise, so no edge is skipped here
   assign load      = accept;                    // Same edge as cs_n assertion
   assign capture   = (state == XFER_FINISH);    // rx_reg already complete
   assign shift_en  = (state == XFER_SHIFT);
   assign phase.run = (state == XFER_SHIFT);     // Divider runs only while shifting

endmodule

// ==== verilog/spi_master.sv ====
// Single slave, mode 3, 8-bit words; a start while busy is dropped
`timescale 1ns/1ps

module spi_master (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              start,    // One-cycle request
   input  logic [spi_pkg::SPI_WORD_BITS-1:0] tx_data,  // Sampled with start
   input  logic                              miso,
   output logic [spi_pkg::SPI_WORD_BITS-1:0] rx_data,  // Valid at done
   output logic                              busy,
   output logic                              done,
   output logic                              sclk,
   output logic                              mosi,
   output logic                              cs_n
);

   // ---------------------------------------------------------------------
   // Internal wiring
   // ---------------------------------------------------------------------
   spi_phase_if phase ();   // run, sclk and edge strobes

   logic load;              // Controller to shift unit
   logic capture;
   logic shift_en;

   assign sclk = phase.sclk;

   // ---------------------------------------------------------------------
   // Blocks
   // ---------------------------------------------------------------------
   spi_sclk_gen spi_sclk_gen_inst (
      .clk   (clk),
      .rst   (rst),
      .phase (phase.gen)
   );

   spi_shift_unit spi_shift_unit_inst (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .capture  (capture),
      .shift_en (shift_en),
      .tx_data  (tx_data),
      .miso     (miso),
      .mosi     (mosi),
      .rx_data  (rx_data),
      .phase    (phase.shift)
   );

   spi_transfer_ctrl spi_transfer_ctrl_inst (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .cs_n     (cs_n),
      .busy     (busy),
      .done     (done),
      .load     (load),
      .capture  (capture),
      .shift_en (shift_en),
      .phase    (phase.ctrl)
   );

endmodule

// ==== verification/spi_master_properties.sv ====
// Watches the top-level SPI pins only; every check is off while rst is high
`timescale 1ns/1ps

module spi_master_properties (
   input logic clk,
   input logic rst,
   input logic cs_n,
   input logic sclk,
   input logic mosi,
   input logic done
);

   // ---------------------------------------------------------------------
   // Chip select framing
   // ---------------------------------------------------------------------
   // Held low through the transfer, released only together with done
   property cs_release_with_done;
      @(posedge clk) disable iff (rst) $rose(cs_n) |-> done;
   endproperty

   // ---------------------------------------------------------------------
   // Serial clock, data and strobes
   // ---------------------------------------------------------------------
   property sclk_idle_high;
      @(posedge clk) disable iff (rst) cs_n |-> sclk;  // CPOL = 1
   endproperty

   // Mode 3 data moves on the low phase, or with bit 7 at select
   property mosi_stable_high_phase;
      @(posedge clk) disable iff (rst) $changed(mosi) |-> (!sclk || $fell(cs_n));
   endproperty

   property done_single_cycle;
      @(posedge clk) disable iff (rst) done |=> !done;
   endproperty

   assert property (cs_release_with_done)   else $error("cs_n released without done");
   assert property (sclk_idle_high)         else $error("sclk low while deselected");
   assert property (mosi_stable_high_phase) else $error("mosi changed while sclk high");
   assert property (done_single_cycle)      else $error("done wider than one cycle");

endmodule

// ==== verification/spi_master_tb.sv ====
// Mode 3 slave model reacts on falling clk edges; all DUT inputs change there too
`timescale 1ns/1ps

module spi_master_tb;

   import spi_pkg::*;

   // ---------------------------------------------------------------------
   // Run length and limits
   // ---------------------------------------------------------------------
   localparam int          CLK_PERIOD_NS  = 8;
   localparam int          RANDOM_XFERS   = 40;
   localparam int          NUM_XFERS      = RANDOM_XFERS + 4;  // Fixed, mid start, pair
   localparam int          XFER_CYCLES    = 16 * SCLK_HALF_CYCLES + 10;
   localparam int          TIMEOUT_MARGIN = 200;               // Reset and idle gaps
   localparam int          TIMEOUT_CYCLES = NUM_XFERS * XFER_CYCLES + TIMEOUT_MARGIN;
   localparam int unsigned RAND_SEED      = 32'hb29d7668;

   logic      clk  = 1'b0;
   logic      rst;
   logic      start;
   spi_word_t tx_data;
   logic      miso = 1'b0;     // Owned by the slave model
   spi_word_t rx_data;
   logic      busy;
   logic      done;
   logic      sclk;
   logic      mosi;
   logic      cs_n;

   // Slave model state
   spi_word_t  next_resp   = '0;    // Response for the next select
   spi_word_t  slave_resp  = '0;    // Response of the current transfer
   spi_word_t  slave_rec   = '0;    // mosi bits seen so far
   logic       sclk_prev   = 1'b1;
   logic       cs_prev     = 1'b1;
   logic [2:0] drive_idx   = '0;
   int         rise_cnt    = 0;
   int         cs_fall_cnt = 0;

   spi_word_t tx_queue[$];         // tx bytes in launch order
   int        error_count = 0;
   int        done_count  = 0;
   int        cycle_cnt   = 0;

   spi_master spi_master_inst (
      .clk     (clk),
      .rst     (rst),
      .start   (start),
      .tx_data (tx_data),
      .miso    (miso),
      .rx_data (rx_data),
      .busy    (busy),
      .done    (done),
      .sclk    (sclk),
      .mosi    (mosi),
      .cs_n    (cs_n)
   );

   bind spi_master spi_master_properties spi_master_properties_inst (
      .clk  (clk),
      .rst  (rst),
      .cs_n (cs_n),
      .sclk (sclk),
      .mosi (mosi),
      .done (done)
   );

   always #(CLK_PERIOD_NS / 2) clk = ~clk;

   // ---------------------------------------------------------------------
   // Mode 3 slave
   // ---------------------------------------------------------------------
   always @(negedge clk) begin
      sclk_prev <= sclk;
      cs_prev   <= cs_n;
      if (cs_prev && !cs_n) begin           // Select, new frame
         slave_resp  <= next_resp;
         slave_rec   <= '0;
         rise_cnt    <= 0;
         drive_idx   <= '0;
         cs_fall_cnt <= cs_fall_cnt + 1;
      end else if (!cs_n) begin
         if (sclk_prev && !sclk) begin      // Drive on fall, MSB first
            miso      <= slave_resp[3'd7 - drive_idx];
            drive_idx <= drive_idx + 3'd1;
         end
         if (!sclk_prev && sclk) begin      // Sample on rise
            slave_rec <= {slave_rec[SPI_WORD_BITS-2:0], mosi};
            rise_cnt  <= rise_cnt + 1;
         end
      end
   end

   // Byte the master should assemble from the slave's MSB-first stream
   function automatic spi_word_t expected_rx(input spi_word_t resp);
      spi_word_t acc;
      acc = '0;
      for (int i = SPI_WORD_BITS - 1; i >= 0; i--) begin
         acc = {acc[SPI_WORD_BITS-2:0], resp[i]};
      end
      return acc;
   endfunction

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
         error_count++;
      end
   endtask

   // ---------------------------------------------------------------------
   // Result checking at each done
   // ---------------------------------------------------------------------
   always @(negedge clk) begin : compare_results
      spi_word_t exp_tx;
      if (!rst && done) begin
         if (tx_queue.size() == 0) begin
            $display("ERROR at %0t: done pulse with no transfer launched", $time);
            error_count++;
         end else begin
            exp_tx = tx_queue.pop_front();
            check_value("tx byte at slave", 32'(slave_rec), 32'(exp_tx));
            check_value("rx_data", 32'(rx_data), 32'(expected_rx(slave_resp)));
            check_value("sclk rises", 32'(rise_cnt), 32'(SPI_WORD_BITS));
         end
         done_count++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("ERROR: timeout after %0d cycles, a transfer never finished", cycle_cnt);
         $display("Testbench failed");
         $finish;
      end
   end

   // ---------------------------------------------------------------------
   // Stimulus
   // ---------------------------------------------------------------------
   task automatic launch_transfer(input spi_word_t tx, input spi_word_t resp);
      tx_data   = tx;
      next_resp = resp;
      start     = 1'b1;
      tx_queue.push_back(tx);
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_for_done;
      while (done !== 1'b1) @(negedge clk);   // Timeout block guards this
   endtask

   task automatic run_transfer(input spi_word_t tx, input spi_word_t resp);
      launch_transfer(tx, resp);
      wait_for_done();
      @(negedge clk);
   endtask

   initial begin : stimulus
      int        gap;
      int        falls_before;
      spi_word_t held_rx;
      void'($urandom(RAND_SEED));
      rst     = 1'b1;
      start   = 1'b0;
      tx_data = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      // Idle levels
      check_value("cs_n idle", 32'(cs_n), 32'd1);
      check_value("sclk idle", 32'(sclk), 32'd1);
      check_value("busy idle", 32'(busy), 32'd0);
      check_value("done idle", 32'(done), 32'd0);
      check_value("mosi idle", 32'(mosi), 32'd0);
      check_value("rx_data idle", 32'(rx_data), 32'd0);

      run_transfer(8'hA5, 8'h3C);           // Fixed pattern

      for (int n = 0; n < RANDOM_XFERS; n++) begin
         gap = $urandom_range(3, 0);
         repeat (gap) @(negedge clk);
         run_transfer(spi_word_t'($urandom), spi_word_t'($urandom));
      end

      // Start pulse in mid transfer must be dropped
      falls_before = cs_fall_cnt;
      launch_transfer(8'h96, 8'h5A);
      repeat (5 * SCLK_HALF_CYCLES) @(negedge clk);
      check_value("busy mid transfer", 32'(busy), 32'd1);
      tx_data = 8'h69;
      start   = 1'b1;
      @(negedge clk);
      start = 1'b0;
      wait_for_done();
      repeat (4 * SCLK_HALF_CYCLES) begin
         @(negedge clk);
         check_value("busy after ignored start", 32'(busy), 32'd0);
         check_value("cs_n after ignored start", 32'(cs_n), 32'd1);
      end
      check_value("selects for one transfer", 32'(cs_fall_cnt - falls_before), 32'd1);

      // Back to back, second start lands in the done cycle
      launch_transfer(8'hC3, 8'h81);
      wait_for_done();
      held_rx = rx_data;
      launch_transfer(8'h1E, 8'hE7);
      check_value("busy on back to back", 32'(busy), 32'd1);
      while (done !== 1'b1) begin
         check_value("rx_data held", 32'(rx_data), 32'(held_rx));
         @(negedge clk);
      end
      repeat (4) @(negedge clk);

      check_value("transfers completed", 32'(done_count), 32'(NUM_XFERS));
      $display("Summary: %0d transfers, %0d errors", done_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
verilog/spi_pkg.sv
verilog/spi_phase_if.sv
verilog/spi_sclk_gen.sv
verilog/spi_shift_unit.sv
verilog/spi_transfer_ctrl.sv
verilog/spi_master.sv
verification/spi_master_properties.sv
verification/spi_master_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SPI master testbench with Verilator and runs it.
# Exits nonzero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

TOP=spi_master_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
   --top-module "$TOP" \
   --Mdir "$BUILD_DIR" \
   -o "$TOP" \
   -f filelist.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$("./$BUILD_DIR/$TOP")
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
   echo "Result: PASS"
   exit 0
fi

echo "Result: FAIL"
exit 1
